//--- src/fetch_pkg.sv
package fetch_pkg;

    typedef logic [31:0] addr_t;  // byte address
    typedef logic [31:0] inst_t;  // raw instruction word

    // major opcodes that change control flow, anything else is ordinary
    typedef enum logic [6:0] {
        op_branch = 7'b1100011,
        op_jalr   = 7'b1100111,
        op_jal    = 7'b1101111
    } opcode_e;

    // 2-bit saturating counter, msb is the taken prediction
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00,
        weak_not_taken   = 2'b01,
        weak_taken       = 2'b10,
        strong_taken     = 2'b11
    } bp_state_e;

    typedef enum logic {
        refill_idle = 1'b0,
        refill_wait = 1'b1
    } refill_state_e;

endpackage

//--- src/fetch_unit.sv
module fetch_unit #(
    parameter int FETCH_WIDTH  = 4,
    parameter int BUFFER_DEPTH = 16,
    localparam int COUNT_W = $clog2(FETCH_WIDTH + 1),
    localparam int SPOTS_W = $clog2(BUFFER_DEPTH + 1)
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 restore_valid,
    input  fetch_pkg::addr_t                     restore_pc,
    output fetch_pkg::addr_t     [FETCH_WIDTH-1:0] fetch_pcs,
    input  fetch_pkg::inst_t     [FETCH_WIDTH-1:0] cache_data,
    input  logic                 [FETCH_WIDTH-1:0] cache_miss,
    input  fetch_pkg::bp_state_e [FETCH_WIDTH-1:0] bp_state,
    input  logic                 [FETCH_WIDTH-1:0] btb_hit,
    input  fetch_pkg::addr_t     [FETCH_WIDTH-1:0] btb_target,
    input  logic                 [SPOTS_W-1:0]     buffer_spots,
    output logic                 [COUNT_W-1:0]     fetch_count,
    output fetch_pkg::inst_t     [FETCH_WIDTH-1:0] entry_inst,
    output fetch_pkg::addr_t     [FETCH_WIDTH-1:0] entry_pc,
    output logic                 [FETCH_WIDTH-1:0] entry_taken,
    output fetch_pkg::addr_t     [FETCH_WIDTH-1:0] entry_predicted_pc,
    output logic                 [FETCH_WIDTH-1:0] entry_is_jump,
    output fetch_pkg::bp_state_e [FETCH_WIDTH-1:0] entry_bp_state,
    output logic                 [FETCH_WIDTH-1:0] last_branch_slot,
    output logic                                 no_branches
);
    import fetch_pkg::*;

    addr_t                  pc_reg;
    addr_t                  next_pc;
    logic [FETCH_WIDTH-1:0] is_branch;
    logic [FETCH_WIDTH-1:0] limit;       // slot i is the first one left out
    logic [FETCH_WIDTH-1:0] branch_accepted;
    logic [COUNT_W-1:0]     cut_count;

    // classify each slot and build its entry
    always_comb begin
        opcode_e op;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            op = opcode_e'(cache_data[i][6:0]);
            fetch_pcs[i]     = pc_reg + 32'(4 * i);
            is_branch[i]     = (op == op_branch);
            entry_is_jump[i] = (op == op_jal) || (op == op_jalr);
            // jumps follow the btb alone, branches also need a taken counter
            entry_taken[i]   = btb_hit[i] && (entry_is_jump[i] ||
                               (is_branch[i] && bp_state[i][1]));
            entry_inst[i]    = cache_data[i];
            entry_pc[i]      = fetch_pcs[i];
            entry_bp_state[i] = bp_state[i];
            entry_predicted_pc[i] = entry_taken[i] ? btb_target[i] : fetch_pcs[i] + 32'd4;
        end
    end

    assign limit = cache_miss | (entry_taken << 1);

    // lowest limiting slot wins, then clamp to the free buffer entries
    always_comb begin
        cut_count = COUNT_W'(FETCH_WIDTH);
        for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
            if (limit[i]) cut_count = COUNT_W'(i);
        end
        if (32'(buffer_spots) < 32'(cut_count)) begin
            fetch_count = COUNT_W'(buffer_spots);
        end else begin
            fetch_count = cut_count;
        end
    end

    // highest accepted branch, handed to the branch stack
    always_comb begin
        last_branch_slot = '0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            branch_accepted[i] = is_branch[i] && (32'(i) < 32'(fetch_count));
        end
        for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
            if (branch_accepted[i] && last_branch_slot == '0) last_branch_slot[i] = 1'b1;
        end
        no_branches = (branch_accepted == '0);
    end

    always_comb begin
        next_pc = pc_reg;  // hold on an empty group
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (32'(i + 1) == 32'(fetch_count)) next_pc = entry_predicted_pc[i];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_reg <= '0;
        end else if (restore_valid) begin
            pc_reg <= restore_pc;
        end else begin
            pc_reg <= next_pc;
        end
    end

endmodule

//--- src/icache.sv
module icache #(
    parameter int FETCH_WIDTH  = 4,
    parameter int ICACHE_LINES = 32
) (
    input  logic                             clock,
    input  logic                             reset,
    input  fetch_pkg::addr_t [FETCH_WIDTH-1:0] fetch_pcs,
    output fetch_pkg::inst_t [FETCH_WIDTH-1:0] cache_data,
    output logic             [FETCH_WIDTH-1:0] cache_miss,
    output logic                             mem_request,
    output fetch_pkg::addr_t                 mem_addr,
    input  logic                             mem_response,
    input  fetch_pkg::inst_t                 mem_data
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(ICACHE_LINES);
    localparam int TAG_W = 30 - IDX_W;

    inst_t                   data_mem [ICACHE_LINES];
    logic [TAG_W-1:0]        tag_mem  [ICACHE_LINES];
    logic [ICACHE_LINES-1:0] line_valid;
    refill_state_e           refill_state;
    addr_t                   miss_pc;
    logic                    start_refill;
    logic                    finish_refill;

    always_comb begin
        miss_pc = fetch_pcs[0];
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            cache_data[i] = data_mem[fetch_pcs[i][IDX_W+1:2]];
            cache_miss[i] = !line_valid[fetch_pcs[i][IDX_W+1:2]] ||
                            (tag_mem[fetch_pcs[i][IDX_W+1:2]] != fetch_pcs[i][31:IDX_W+2]);
        end
        // lowest missing slot is refilled first
        for (int i = FETCH_WIDTH - 1; i >= 0; i--) begin
            if (cache_miss[i]) miss_pc = fetch_pcs[i];
        end
    end

    assign start_refill  = (refill_state == refill_idle) && (|cache_miss);
    assign finish_refill = (refill_state == refill_wait) && mem_response;

    always_ff @(posedge clock) begin
        if (reset) begin
            refill_state <= refill_idle;
            mem_request  <= 1'b0;
            line_valid   <= '0;
        end else begin
            mem_request <= start_refill;  // one cycle pulse
            if (start_refill) begin
                refill_state <= refill_wait;
            end else if (finish_refill) begin
                refill_state <= refill_idle;
                line_valid[mem_addr[IDX_W+1:2]] <= 1'b1;
            end
        end
    end

    // line storage and the address being refilled
    always_ff @(posedge clock) begin
        if (start_refill) mem_addr <= miss_pc;
        if (finish_refill) begin
            data_mem[mem_addr[IDX_W+1:2]] <= mem_data;
            tag_mem[mem_addr[IDX_W+1:2]]  <= mem_addr[31:IDX_W+2];
        end
    end

endmodule

//--- src/branch_predictor.sv
module branch_predictor #(
    parameter int FETCH_WIDTH = 4,
    parameter int BP_ENTRIES  = 64
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  fetch_pkg::addr_t     [FETCH_WIDTH-1:0] fetch_pcs,
    output fetch_pkg::bp_state_e [FETCH_WIDTH-1:0] bp_state,
    input  logic                                 update_valid,
    input  logic                                 update_is_branch,
    input  fetch_pkg::addr_t                     update_pc,
    input  logic                                 update_taken
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(BP_ENTRIES);

    bp_state_e        counters [BP_ENTRIES];
    logic [IDX_W-1:0] update_idx;
    bp_state_e        update_old;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            bp_state[i] = counters[fetch_pcs[i][IDX_W+1:2]];
        end
    end

    assign update_idx = update_pc[IDX_W+1:2];
    assign update_old = counters[update_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < BP_ENTRIES; i++) counters[i] <= weak_not_taken;
        end else if (update_valid && update_is_branch) begin
            // saturate at both ends
            if (update_taken && update_old != strong_taken) begin
                counters[update_idx] <= bp_state_e'(update_old + 2'd1);
            end else if (!update_taken && update_old != strong_not_taken) begin
                counters[update_idx] <= bp_state_e'(update_old - 2'd1);
            end
        end
    end

endmodule

//--- src/btb.sv
module btb #(
    parameter int FETCH_WIDTH = 4,
    parameter int BTB_ENTRIES = 16
) (
    input  logic                             clock,
    input  logic                             reset,
    input  fetch_pkg::addr_t [FETCH_WIDTH-1:0] fetch_pcs,
    output logic             [FETCH_WIDTH-1:0] btb_hit,
    output fetch_pkg::addr_t [FETCH_WIDTH-1:0] btb_target,
    input  logic                             update_valid,
    input  logic                             update_taken,
    input  fetch_pkg::addr_t                 update_pc,
    input  fetch_pkg::addr_t                 update_target
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = 30 - IDX_W;

    addr_t                  target_mem [BTB_ENTRIES];
    logic [TAG_W-1:0]       tag_mem    [BTB_ENTRIES];
    logic [BTB_ENTRIES-1:0] entry_valid;
    logic                   write_en;

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            btb_target[i] = target_mem[fetch_pcs[i][IDX_W+1:2]];
            btb_hit[i]    = entry_valid[fetch_pcs[i][IDX_W+1:2]] &&
                            (tag_mem[fetch_pcs[i][IDX_W+1:2]] == fetch_pcs[i][31:IDX_W+2]);
        end
    end

    assign write_en = update_valid && update_taken;  // only taken outcomes carry a target

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
        end else if (write_en) begin
            entry_valid[update_pc[IDX_W+1:2]] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (write_en) begin
            target_mem[update_pc[IDX_W+1:2]] <= update_target;
            tag_mem[update_pc[IDX_W+1:2]]    <= update_pc[31:IDX_W+2];
        end
    end

endmodule

//--- src/inst_buffer.sv
module inst_buffer #(
    parameter int FETCH_WIDTH  = 4,
    parameter int BUFFER_DEPTH = 16,  // power of two, pointers wrap on their own
    localparam int COUNT_W = $clog2(FETCH_WIDTH + 1),
    localparam int SPOTS_W = $clog2(BUFFER_DEPTH + 1)
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 restore_valid,
    output logic                 [SPOTS_W-1:0]     buffer_spots,
    input  logic                 [COUNT_W-1:0]     fetch_count,
    input  fetch_pkg::inst_t     [FETCH_WIDTH-1:0] entry_inst,
    input  fetch_pkg::addr_t     [FETCH_WIDTH-1:0] entry_pc,
    input  logic                 [FETCH_WIDTH-1:0] entry_taken,
    input  fetch_pkg::addr_t     [FETCH_WIDTH-1:0] entry_predicted_pc,
    input  logic                 [FETCH_WIDTH-1:0] entry_is_jump,
    input  fetch_pkg::bp_state_e [FETCH_WIDTH-1:0] entry_bp_state,
    output logic                 [COUNT_W-1:0]     dispatch_count,
    output fetch_pkg::inst_t     [FETCH_WIDTH-1:0] dispatch_inst,
    output fetch_pkg::addr_t     [FETCH_WIDTH-1:0] dispatch_pc,
    output logic                 [FETCH_WIDTH-1:0] dispatch_taken,
    output fetch_pkg::addr_t     [FETCH_WIDTH-1:0] dispatch_predicted_pc,
    output logic                 [FETCH_WIDTH-1:0] dispatch_is_jump,
    output fetch_pkg::bp_state_e [FETCH_WIDTH-1:0] dispatch_bp_state,
    input  logic                 [COUNT_W-1:0]     dispatch_take
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(BUFFER_DEPTH);

    inst_t     inst_mem  [BUFFER_DEPTH];
    addr_t     pc_mem    [BUFFER_DEPTH];
    addr_t     pred_mem  [BUFFER_DEPTH];
    bp_state_e state_mem [BUFFER_DEPTH];
    logic      taken_mem [BUFFER_DEPTH];
    logic      jump_mem  [BUFFER_DEPTH];

    logic [PTR_W-1:0]   head;
    logic [PTR_W-1:0]   tail;
    logic [SPOTS_W-1:0] occupancy;
    logic [PTR_W-1:0]   rd_ptr;

    assign buffer_spots   = SPOTS_W'(BUFFER_DEPTH) - occupancy;
    assign dispatch_count = (32'(occupancy) >= FETCH_WIDTH) ? COUNT_W'(FETCH_WIDTH)
                                                            : COUNT_W'(occupancy);

    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            rd_ptr = head + PTR_W'(i);
            dispatch_inst[i]         = inst_mem[rd_ptr];
            dispatch_pc[i]           = pc_mem[rd_ptr];
            dispatch_taken[i]        = taken_mem[rd_ptr];
            dispatch_predicted_pc[i] = pred_mem[rd_ptr];
            dispatch_is_jump[i]      = jump_mem[rd_ptr];
            dispatch_bp_state[i]     = state_mem[rd_ptr];
        end
    end

    always_ff @(posedge clock) begin
        if (reset || restore_valid) begin  // flush drops everything, incoming group too
            head      <= '0;
            tail      <= '0;
            occupancy <= '0;
        end else begin
            head      <= head + PTR_W'(dispatch_take);
            tail      <= tail + PTR_W'(fetch_count);
            occupancy <= occupancy + SPOTS_W'(fetch_count) - SPOTS_W'(dispatch_take);
        end
    end

    always_ff @(posedge clock) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (!restore_valid && 32'(i) < 32'(fetch_count)) begin
                inst_mem[tail + PTR_W'(i)]  <= entry_inst[i];
                pc_mem[tail + PTR_W'(i)]    <= entry_pc[i];
                taken_mem[tail + PTR_W'(i)] <= entry_taken[i];
                pred_mem[tail + PTR_W'(i)]  <= entry_predicted_pc[i];
                jump_mem[tail + PTR_W'(i)]  <= entry_is_jump[i];
                state_mem[tail + PTR_W'(i)] <= entry_bp_state[i];
            end
        end
    end

endmodule

//--- src/fetch_top.sv
module fetch_top #(
    parameter int FETCH_WIDTH  = 4,
    parameter int ICACHE_LINES = 32,
    parameter int BP_ENTRIES   = 64,
    parameter int BTB_ENTRIES  = 16,
    parameter int BUFFER_DEPTH = 16,
    localparam int COUNT_W = $clog2(FETCH_WIDTH + 1)
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 restore_valid,
    input  fetch_pkg::addr_t                     restore_pc,
    output logic                                 mem_request,
    output fetch_pkg::addr_t                     mem_addr,
    input  logic                                 mem_response,
    input  fetch_pkg::inst_t                     mem_data,
    input  logic                                 update_valid,
    input  fetch_pkg::addr_t                     update_pc,
    input  logic                                 update_taken,
    input  fetch_pkg::addr_t                     update_target,
    input  logic                                 update_is_branch,
    output logic                 [COUNT_W-1:0]     dispatch_count,
    output fetch_pkg::inst_t     [FETCH_WIDTH-1:0] dispatch_inst,
    output fetch_pkg::addr_t     [FETCH_WIDTH-1:0] dispatch_pc,
    output logic                 [FETCH_WIDTH-1:0] dispatch_taken,
    output fetch_pkg::addr_t     [FETCH_WIDTH-1:0] dispatch_predicted_pc,
    output logic                 [FETCH_WIDTH-1:0] dispatch_is_jump,
    output fetch_pkg::bp_state_e [FETCH_WIDTH-1:0] dispatch_bp_state,
    input  logic                 [COUNT_W-1:0]     dispatch_take,
    output logic                 [FETCH_WIDTH-1:0] last_branch_slot,
    output logic                                 no_branches
);
    import fetch_pkg::*;

    localparam int SPOTS_W = $clog2(BUFFER_DEPTH + 1);

    addr_t     [FETCH_WIDTH-1:0] fetch_pcs;
    inst_t     [FETCH_WIDTH-1:0] cache_data;
    logic      [FETCH_WIDTH-1:0] cache_miss;
    bp_state_e [FETCH_WIDTH-1:0] bp_state;
    logic      [FETCH_WIDTH-1:0] btb_hit;
    addr_t     [FETCH_WIDTH-1:0] btb_target;
    logic      [SPOTS_W-1:0]     buffer_spots;
    logic      [COUNT_W-1:0]     fetch_count;

    // fetch group entries on their way into the buffer
    inst_t     [FETCH_WIDTH-1:0] entry_inst;
    addr_t     [FETCH_WIDTH-1:0] entry_pc;
    logic      [FETCH_WIDTH-1:0] entry_taken;
    addr_t     [FETCH_WIDTH-1:0] entry_predicted_pc;
    logic      [FETCH_WIDTH-1:0] entry_is_jump;
    bp_state_e [FETCH_WIDTH-1:0] entry_bp_state;

    fetch_unit #(.FETCH_WIDTH(FETCH_WIDTH), .BUFFER_DEPTH(BUFFER_DEPTH)) u_fetch_unit (
        .clock, .reset, .restore_valid, .restore_pc, .fetch_pcs,
        .cache_data, .cache_miss, .bp_state, .btb_hit, .btb_target,
        .buffer_spots, .fetch_count, .entry_inst, .entry_pc, .entry_taken,
        .entry_predicted_pc, .entry_is_jump, .entry_bp_state,
        .last_branch_slot, .no_branches
    );

    icache #(.FETCH_WIDTH(FETCH_WIDTH), .ICACHE_LINES(ICACHE_LINES)) u_icache (
        .clock, .reset, .fetch_pcs, .cache_data, .cache_miss,
        .mem_request, .mem_addr, .mem_response, .mem_data
    );

    branch_predictor #(.FETCH_WIDTH(FETCH_WIDTH), .BP_ENTRIES(BP_ENTRIES)) u_bp (
        .clock, .reset, .fetch_pcs, .bp_state,
        .update_valid, .update_is_branch, .update_pc, .update_taken
    );

    btb #(.FETCH_WIDTH(FETCH_WIDTH), .BTB_ENTRIES(BTB_ENTRIES)) u_btb (
        .clock, .reset, .fetch_pcs, .btb_hit, .btb_target,
        .update_valid, .update_taken, .update_pc, .update_target
    );

    inst_buffer #(.FETCH_WIDTH(FETCH_WIDTH), .BUFFER_DEPTH(BUFFER_DEPTH)) u_inst_buffer (
        .clock, .reset, .restore_valid, .buffer_spots, .fetch_count,
        .entry_inst, .entry_pc, .entry_taken, .entry_predicted_pc,
        .entry_is_jump, .entry_bp_state, .dispatch_count, .dispatch_inst,
        .dispatch_pc, .dispatch_taken, .dispatch_predicted_pc,
        .dispatch_is_jump, .dispatch_bp_state, .dispatch_take
    );

endmodule

//--- sim/fetch_sva.sv
module fetch_sva #(
    parameter int FETCH_WIDTH  = 4,
    parameter int BUFFER_DEPTH = 16,
    localparam int COUNT_W = $clog2(FETCH_WIDTH + 1),
    localparam int SPOTS_W = $clog2(BUFFER_DEPTH + 1)
) (
    input logic                   clock,
    input logic                   reset,
    input logic [COUNT_W-1:0]     fetch_count,
    input logic [SPOTS_W-1:0]     buffer_spots,
    input logic [FETCH_WIDTH-1:0] last_branch_slot,
    input logic                   no_branches
);
    // a fetch group never overruns the free buffer entries
    count_within_spots: assert property (@(posedge clock) disable iff (reset)
        32'(fetch_count) <= 32'(buffer_spots))
        else $error("fetch_count %0d exceeds buffer_spots %0d", fetch_count, buffer_spots);

    branch_slot_onehot: assert property (@(posedge clock) disable iff (reset)
        $onehot0(last_branch_slot))
        else $error("last_branch_slot %b has more than one bit set", last_branch_slot);

    no_branches_consistent: assert property (@(posedge clock) disable iff (reset)
        no_branches == (last_branch_slot == '0))
        else $error("no_branches %b disagrees with last_branch_slot %b", no_branches,
                    last_branch_slot);
endmodule

bind fetch_unit fetch_sva #(.FETCH_WIDTH(FETCH_WIDTH), .BUFFER_DEPTH(BUFFER_DEPTH)) u_fetch_sva (
    .clock, .reset, .fetch_count, .buffer_spots, .last_branch_slot, .no_branches
);

//--- sim/fetch_tb.sv
module fetch_tb;
    import fetch_pkg::*;

    localparam int FETCH_WIDTH  = 4;
    localparam int ICACHE_LINES = 32;
    localparam int BP_ENTRIES   = 64;
    localparam int BTB_ENTRIES  = 16;
    localparam int BUFFER_DEPTH = 16;
    localparam int COUNT_W      = $clog2(FETCH_WIDTH + 1);
    localparam addr_t BRANCH_PC  = 32'h0000_0200;
    localparam addr_t BRANCH_TGT = 32'h0000_0280;
    localparam addr_t JAL_PC     = 32'h0000_0304;  // counter slot differs from BRANCH_PC
    localparam addr_t JAL_TGT    = 32'h0000_0380;

    logic clock, reset, restore_valid, mem_request, mem_response;
    logic update_valid, update_taken, update_is_branch, no_branches;
    addr_t restore_pc, mem_addr, update_pc, update_target, exp_pc, req_addr;
    inst_t mem_data;
    logic      [COUNT_W-1:0]     dispatch_count, dispatch_take;
    inst_t     [FETCH_WIDTH-1:0] dispatch_inst;
    addr_t     [FETCH_WIDTH-1:0] dispatch_pc, dispatch_predicted_pc;
    logic      [FETCH_WIDTH-1:0] dispatch_taken, dispatch_is_jump, last_branch_slot;
    bp_state_e [FETCH_WIDTH-1:0] dispatch_bp_state;

    inst_t       prog [256];                 // program image behind the refill port
    bp_state_e   bp_model [BP_ENTRIES];
    logic        btb_valid [BTB_ENTRIES];
    addr_t       btb_pc [BTB_ENTRIES];
    addr_t       btb_tgt [BTB_ENTRIES];
    logic        line_valid [ICACHE_LINES];  // which word each cache line holds
    addr_t       line_addr [ICACHE_LINES];
    int          checks = 0, errors = 0, errors_before = 0, req_count = 0, req_before;
    int unsigned delay_left = 0;
    logic [31:0] rng = 32'h2428_d6d9;

    fetch_top #(
        .FETCH_WIDTH(FETCH_WIDTH), .ICACHE_LINES(ICACHE_LINES), .BP_ENTRIES(BP_ENTRIES),
        .BTB_ENTRIES(BTB_ENTRIES), .BUFFER_DEPTH(BUFFER_DEPTH)
    ) uut (.*);

    initial clock = 1'b0;
    always #10 clock = ~clock;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic inst_t fill_word(input addr_t a);
        return {a[31:7] ^ a[24:0], 7'h13};  // addi, never a control transfer
    endfunction

    function automatic int table_index(input addr_t a, input int entries);
        return int'((a >> 2) % entries);
    endfunction

    // memory model, one request outstanding, 1 to 6 cycles of latency
    always @(posedge clock) begin
        mem_response <= 1'b0;
        if (delay_left > 0) begin
            delay_left = delay_left - 1;
            if (delay_left == 0) begin
                mem_response <= 1'b1;
                mem_data     <= prog[req_addr[9:2]];
            end
        end
        if (!reset && mem_request) begin
            req_count++;
            if (line_valid[table_index(mem_addr, ICACHE_LINES)] &&
                line_addr[table_index(mem_addr, ICACHE_LINES)] == mem_addr) begin
                errors++;
                $display("refill requested for %h although it is already cached", mem_addr);
            end
            line_valid[table_index(mem_addr, ICACHE_LINES)] = 1'b1;
            line_addr[table_index(mem_addr, ICACHE_LINES)]  = mem_addr;
            rng        = xorshift(rng);
            delay_left = 1 + rng % 6;
            req_addr   = mem_addr;
        end
    end

    task automatic report(input string name, input logic [31:0] got, input logic [31:0] exp);
        errors++;
        $display("mismatch %s: got %h, expected %h", name, got, exp);
    endtask

    task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp) report(name, got, exp);
    endtask

    task automatic compare_inst(input string name, input inst_t got, input inst_t exp);
        checks++;
        if (got !== exp) report(name, got, exp);
    endtask

    task automatic compare_state(input string name, input bp_state_e got, input bp_state_e exp);
        checks++;
        if (got !== exp) report(name, 32'(got), 32'(exp));
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) report(name, 32'(got), 32'(exp));
    endtask

    task automatic compare_count(input string name, input logic [COUNT_W-1:0] got,
                                 input logic [COUNT_W-1:0] exp);
        checks++;
        if (got !== exp) report(name, 32'(got), 32'(exp));
    endtask

    task automatic compare_slots(input string name, input logic [FETCH_WIDTH-1:0] got,
                                 input logic [FETCH_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) report(name, 32'(got), 32'(exp));
    endtask

    // reference walker, checks one dispatch slot against the predicted path
    task automatic check_entry(input int i);
        inst_t     inst;
        opcode_e   op;
        bp_state_e state;
        logic      jump;
        logic      taken;
        int        b;
        inst  = prog[exp_pc[9:2]];
        op    = opcode_e'(inst[6:0]);
        jump  = (op == op_jal) || (op == op_jalr);
        state = bp_model[table_index(exp_pc, BP_ENTRIES)];
        b     = table_index(exp_pc, BTB_ENTRIES);
        taken = btb_valid[b] && btb_pc[b] == exp_pc &&
                (jump || (op == op_branch && state inside {weak_taken, strong_taken}));
        compare_addr($sformatf("dispatch_pc[%0d]", i), dispatch_pc[i], exp_pc);
        compare_inst($sformatf("dispatch_inst[%0d]", i), dispatch_inst[i], inst);
        compare_bit($sformatf("dispatch_taken[%0d]", i), dispatch_taken[i], taken);
        compare_bit($sformatf("dispatch_is_jump[%0d]", i), dispatch_is_jump[i], jump);
        compare_state($sformatf("dispatch_bp_state[%0d]", i), dispatch_bp_state[i], state);
        exp_pc = taken ? btb_tgt[b] : exp_pc + 32'd4;
        compare_addr($sformatf("dispatch_predicted_pc[%0d]", i),
                     dispatch_predicted_pc[i], exp_pc);
    endtask

    // pop n entries, looking at the outputs on the falling edge
    task automatic consume(input int n);
        int got;
        int idle;
        int k;
        got  = 0;
        idle = 0;
        while (got < n && idle < 400) begin
            @(negedge clock);
            k = (int'(dispatch_count) < n - got) ? int'(dispatch_count) : n - got;
            for (int i = 0; i < k; i++) check_entry(i);
            got  = got + k;
            idle = (k == 0) ? idle + 1 : 0;
            @(posedge clock);
            dispatch_take <= COUNT_W'(k);
            @(posedge clock);
            dispatch_take <= '0;  // popped at this edge
        end
        if (got < n) begin
            errors++;
            $display("dispatch stalled, only %0d of %0d entries arrived", got, n);
        end
    endtask

    task automatic wait_quiet();
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 20 && cycles < 1000) begin
            @(posedge clock);
            quiet  = mem_request ? 0 : quiet + 1;
            cycles = cycles + 1;
        end
        if (quiet < 20) begin
            errors++;
            $display("refill traffic did not settle within %0d cycles", cycles);
        end
    endtask

    task automatic restore(input addr_t pc);
        @(posedge clock);
        restore_valid <= 1'b1;
        restore_pc    <= pc;
        @(posedge clock);
        restore_valid <= 1'b0;
        exp_pc = pc;
    endtask

    task automatic train(input addr_t pc, input logic taken, input addr_t target,
                         input logic is_branch);
        int p;
        int b;
        p = table_index(pc, BP_ENTRIES);
        b = table_index(pc, BTB_ENTRIES);
        @(posedge clock);
        update_valid     <= 1'b1;
        update_pc        <= pc;
        update_taken     <= taken;
        update_target    <= target;
        update_is_branch <= is_branch;
        @(posedge clock);
        update_valid <= 1'b0;
        if (is_branch && taken && bp_model[p] != strong_taken) begin
            bp_model[p] = bp_state_e'(bp_model[p] + 2'd1);
        end else if (is_branch && !taken && bp_model[p] != strong_not_taken) begin
            bp_model[p] = bp_state_e'(bp_model[p] - 2'd1);
        end
        if (taken) begin
            btb_valid[b] = 1'b1;
            btb_pc[b]    = pc;
            btb_tgt[b]   = target;
        end
    endtask

    task automatic end_test(input string name);
        $display("%-14s %s", name, (errors == errors_before) ? "ok" : "failed");
        errors_before = errors;
    endtask

    initial begin
        reset            = 1'b1;
        restore_valid    = 1'b0;
        restore_pc       = '0;
        mem_response     = 1'b0;
        mem_data         = '0;
        update_valid     = 1'b0;
        update_pc        = '0;
        update_taken     = 1'b0;
        update_target    = '0;
        update_is_branch = 1'b0;
        dispatch_take    = '0;
        for (int i = 0; i < 256; i++) prog[i] = fill_word(addr_t'(4 * i));
        prog[BRANCH_PC[9:2]] = {25'h000_1041, op_branch};
        prog[JAL_PC[9:2]]    = {25'h010_0000, op_jal};
        for (int i = 0; i < BP_ENTRIES; i++) bp_model[i] = weak_not_taken;
        for (int i = 0; i < BTB_ENTRIES; i++) btb_valid[i] = 1'b0;
        for (int i = 0; i < ICACHE_LINES; i++) line_valid[i] = 1'b0;
        repeat (8) @(posedge clock);
        reset  <= 1'b0;
        exp_pc = '0;

        consume(8);  // cold start from pc 0
        end_test("sequential");

        wait_quiet();
        restore(32'h0);
        req_before = req_count;
        consume(8);
        wait_quiet();
        if (req_count != req_before) begin
            errors++;
            $display("replay from pc 0 issued %0d refill requests", req_count - req_before);
        end
        end_test("refill");

        wait_quiet();  // buffer full, nothing taken
        @(negedge clock);
        compare_count("dispatch_count", dispatch_count, COUNT_W'(FETCH_WIDTH));
        consume(40);
        end_test("backpressure");

        train(BRANCH_PC, 1'b1, BRANCH_TGT, 1'b1);
        restore(BRANCH_PC - 32'd8);
        consume(6);
        // buffer fills up to the branch, which then waits in slot 0
        restore(BRANCH_PC - 32'(4 * BUFFER_DEPTH));
        wait_quiet();
        @(negedge clock);
        compare_slots("last_branch_slot", last_branch_slot, '0);
        compare_bit("no_branches", no_branches, 1'b1);
        consume(1);
        @(negedge clock);  // one free entry, the taken branch alone is accepted
        compare_slots("last_branch_slot", last_branch_slot, FETCH_WIDTH'(1));
        compare_bit("no_branches", no_branches, 1'b0);
        end_test("branch");

        restore(JAL_PC - 32'd8);
        consume(6);  // jal not in the btb yet
        train(JAL_PC, 1'b1, JAL_TGT, 1'b0);
        restore(JAL_PC - 32'd8);
        consume(6);
        end_test("jump");

        wait_quiet();
        restore(32'h0000_03c0);
        @(negedge clock);
        compare_count("dispatch_count", dispatch_count, '0);
        consume(4);
        end_test("restore");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end
endmodule

//--- verilog.f
src/fetch_pkg.sv
src/fetch_unit.sv
src/icache.sv
src/branch_predictor.sv
src/btb.sv
src/inst_buffer.sv
src/fetch_top.sv
sim/fetch_sva.sv
sim/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - src/fetch_pkg.sv
  - src/fetch_unit.sv
  - src/icache.sv
  - src/branch_predictor.sv
  - src/btb.sv
  - src/inst_buffer.sv
  - src/fetch_top.sv
  - target: simulation
    files:
      - sim/fetch_sva.sv
      - sim/fetch_tb.sv
